/* common/mist_glue_defines.svh */
`ifndef MIST_GLUE_DEFINES_SVH
`define MIST_GLUE_DEFINES_SVH

// external RAM bus
`define MG_MEM_ADDR_W 24
`define MG_MEM_DATA_W 32
`define MG_MEM_SEL_W 4

// word address drops the two byte-lane bits
`define MG_MEM_WADDR_W (`MG_MEM_ADDR_W - 2)

// video
`define MG_COLOR_W 4

// data_io loader
`define MG_DIO_INDEX_W 8

// indices that load ROM images into RAM
`define MG_IDX_ROM_LO 1
`define MG_IDX_ROM_HI 2

// back-porch blanking lengths in pixel cycles
`define MG_BLANK_TV 256
`define MG_BLANK_VGA 64

// cycles to wait for the reconfig controller to drop busy
`define MG_RECONFIG_TIMEOUT 1000

// width of the reconfig timeout counter
`define MG_RECONFIG_CNT_W 10

`endif

/* common/mist_glue_pkg.sv */
`include "mist_glue_defines.svh"

package mist_glue_pkg;

	// wishbone-style request towards the RAM controller
	typedef struct packed {
		logic                         stb;
		logic                         we;
		logic [`MG_MEM_SEL_W-1:0]     sel;
		// word address, byte address bits 23..2
		logic [`MG_MEM_WADDR_W-1:0]   adr;
		logic [`MG_MEM_DATA_W-1:0]    wdata;
	} mem_req_t;

	// one write from the ROM loader, we is a single-cycle pulse
	typedef struct packed {
		logic                         we;
		logic [`MG_MEM_SEL_W-1:0]     sel;
		logic [`MG_MEM_ADDR_W-1:0]    addr;
		logic [`MG_MEM_DATA_W-1:0]    data;
	} loader_req_t;

	typedef struct packed {
		logic [`MG_COLOR_W-1:0] r;
		logic [`MG_COLOR_W-1:0] g;
		logic [`MG_COLOR_W-1:0] b;
	} rgb_t;

	typedef struct packed {
		rgb_t rgb;
		logic hs;
		logic vs;
	} video_t;

	// pixel base clock select from the core
	// 2'b11 is not defined and is handled as 24 MHz
	typedef enum logic [1:0] {
		PIXBASE_24 = 2'b00,
		PIXBASE_25 = 2'b01,
		PIXBASE_36 = 2'b10
	} pixbase_e;

endpackage

/* design/mem_arbiter/mem_arbiter.sv */
`timescale 1ns/1ps
`include "mist_glue_defines.svh"

module mem_arbiter (
	input  logic                         clk_sys,
	input  logic                         rst_n_i,
	input  mist_glue_pkg::mem_req_t      core_req_i,
	input  mist_glue_pkg::loader_req_t   loader_req_i,
	input  logic                         downloading_i,
	input  logic [`MG_DIO_INDEX_W-1:0]   dio_index_i,
	input  logic                         ram_ack_i,
	input  logic                         ram_ready_i,
	output mist_glue_pkg::mem_req_t      ram_req_o,
	output logic                         core_ack_o,
	output logic                         core_reset_o
);

	logic loader_active;
	logic loader_active_q;
	logic loader_stb;
	logic rom_ready;

	// only the ROM image indices write into RAM
	assign loader_active = downloading_i &&
		((dio_index_i == `MG_DIO_INDEX_W'(`MG_IDX_ROM_LO)) ||
		 (dio_index_i == `MG_DIO_INDEX_W'(`MG_IDX_ROM_HI)));

	// loader strobe held until the RAM acknowledges
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			loader_stb <= 1'b0;
		end else if (loader_active && loader_req_i.we) begin
			loader_stb <= 1'b1;
		end else if (ram_ack_i) begin
			loader_stb <= 1'b0;
		end
	end

	// rom_ready latches on the falling edge of loader_active
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			loader_active_q <= 1'b0;
			rom_ready       <= 1'b0;
		end else begin
			loader_active_q <= loader_active;
			if (loader_active_q && !loader_active) begin
				rom_ready <= 1'b1;
			end
		end
	end

	// core stays in reset until RAM is up and the ROM is in place
	assign core_reset_o = ~(ram_ready_i & rom_ready);

	always_comb begin
		if (loader_active) begin
			ram_req_o.stb   = loader_stb;
			ram_req_o.we    = 1'b1;
			ram_req_o.sel   = loader_req_i.sel;
			ram_req_o.adr   = loader_req_i.addr[`MG_MEM_ADDR_W-1:2];
			ram_req_o.wdata = loader_req_i.data;
			core_ack_o      = 1'b0;
		end else begin
			// core owns the bus, no added latency
			ram_req_o       = core_req_i;
			core_ack_o      = ram_ack_i;
		end
	end

endmodule

/* design/pll_reconfig/pll_reconfig_seq.sv */
`timescale 1ns/1ps
`include "mist_glue_defines.svh"

module pll_reconfig_seq (
	input  logic                    clk_sys,
	input  logic                    rst_n_i,
	input  mist_glue_pkg::pixbase_e pixbase_sel_i,
	input  logic                    reconfig_busy_i,
	input  logic                    rom_q_24_i,
	input  logic                    rom_q_25_i,
	input  logic                    rom_q_36_i,
	output logic                    write_from_rom_o,
	output logic                    reconfig_o,
	output logic                    reconfig_reset_o,
	output logic                    rom_q_o
);

	typedef enum logic [1:0] {
		ST_IDLE      = 2'b00,
		ST_SETTLE    = 2'b01,
		ST_WAIT_NB   = 2'b10,
		ST_WAIT_DONE = 2'b11
	} state_e;

	state_e                         state;
	mist_glue_pkg::pixbase_e        sel_q;
	logic [`MG_RECONFIG_CNT_W-1:0]  timeout;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			state            <= ST_IDLE;
			sel_q            <= mist_glue_pkg::PIXBASE_24;
			timeout          <= '0;
			write_from_rom_o <= 1'b0;
			reconfig_o       <= 1'b0;
			reconfig_reset_o <= 1'b0;
		end else begin
			// all controller strobes are single-cycle
			write_from_rom_o <= 1'b0;
			reconfig_o       <= 1'b0;
			reconfig_reset_o <= 1'b0;

			case (state)
				ST_IDLE: begin
					sel_q <= pixbase_sel_i;
					if (pixbase_sel_i != sel_q) begin
						// new clock selected, reload scan chain from ROM
						write_from_rom_o <= 1'b1;
						state            <= ST_SETTLE;
					end
				end
				// give the controller a cycle to raise busy
				ST_SETTLE: begin
					state <= ST_WAIT_NB;
				end
				ST_WAIT_NB: begin
					if (!reconfig_busy_i) begin
						reconfig_o <= 1'b1;
						timeout    <= `MG_RECONFIG_CNT_W'(`MG_RECONFIG_TIMEOUT);
						state      <= ST_WAIT_DONE;
					end
				end
				ST_WAIT_DONE: begin
					timeout <= timeout - 1'b1;
					if (timeout == `MG_RECONFIG_CNT_W'(1)) begin
						// controller stuck in busy
						reconfig_reset_o <= 1'b1;
						state            <= ST_IDLE;
					end
					if (!reconfig_o && !reconfig_busy_i) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// scan data bit from the ROM matching the selected clock
	always_comb begin
		case (pixbase_sel_i)
			mist_glue_pkg::PIXBASE_25: rom_q_o = rom_q_25_i;
			mist_glue_pkg::PIXBASE_36: rom_q_o = rom_q_36_i;
			default:                   rom_q_o = rom_q_24_i;
		endcase
	end

endmodule

/* design/video_blank/back_porch_blank.sv */
`timescale 1ns/1ps
`include "mist_glue_defines.svh"

module back_porch_blank (
	input  logic                    clk_sys,
	input  logic                    rst_n_i,
	input  logic                    ce_pix_i,
	input  mist_glue_pkg::pixbase_e pixbase_sel_i,
	input  mist_glue_pkg::video_t   vid_i,
	output mist_glue_pkg::video_t   vid_o
);

	logic [7:0] pix_cnt;
	logic       tv_mode;
	logic       back_porch_n;

	// 24 MHz base (or undefined 2'b11) means TV timing
	assign tv_mode = (pixbase_sel_i[0] == pixbase_sel_i[1]);

	// high once the porch is over: 256 cycles in TV mode, 64 in VGA mode
	assign back_porch_n = tv_mode ? (pix_cnt == 8'(`MG_BLANK_TV - 1))
		: (pix_cnt[5:0] == 6'(`MG_BLANK_VGA - 1));

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			pix_cnt <= '0;
		end else if (!vid_o.hs) begin
			pix_cnt <= '0;
		end else if (!back_porch_n) begin
			pix_cnt <= pix_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			vid_o <= '0;
		end else if (ce_pix_i) begin
			vid_o.hs <= vid_i.hs;
			vid_o.vs <= vid_i.vs;
			// force black inside the back porch
			if (back_porch_n) begin
				vid_o.rgb <= vid_i.rgb;
			end else begin
				vid_o.rgb <= '0;
			end
		end
	end

endmodule

/* design/mist_glue_top.sv */
`timescale 1ns/1ps
`include "mist_glue_defines.svh"

module mist_glue_top (
	input  logic                         clk_sys,
	input  logic                         rst_n_i,

	// memory bus
	input  mist_glue_pkg::mem_req_t      core_req_i,
	input  mist_glue_pkg::loader_req_t   loader_req_i,
	input  logic                         downloading_i,
	input  logic [`MG_DIO_INDEX_W-1:0]   dio_index_i,
	input  logic                         ram_ack_i,
	input  logic                         ram_ready_i,
	output mist_glue_pkg::mem_req_t      ram_req_o,
	output logic                         core_ack_o,
	output logic                         core_reset_o,

	// pll reconfiguration
	input  mist_glue_pkg::pixbase_e      pixbase_sel_i,
	input  logic                         reconfig_busy_i,
	input  logic                         rom_q_24_i,
	input  logic                         rom_q_25_i,
	input  logic                         rom_q_36_i,
	output logic                         write_from_rom_o,
	output logic                         reconfig_o,
	output logic                         reconfig_reset_o,
	output logic                         rom_q_o,

	// video
	input  mist_glue_pkg::video_t        vid_i,
	input  logic                         ce_pix_i,
	output mist_glue_pkg::video_t        vid_o
);

	mem_arbiter i_mem_arbiter (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.core_req_i    (core_req_i),
		.loader_req_i  (loader_req_i),
		.downloading_i (downloading_i),
		.dio_index_i   (dio_index_i),
		.ram_ack_i     (ram_ack_i),
		.ram_ready_i   (ram_ready_i),
		.ram_req_o     (ram_req_o),
		.core_ack_o    (core_ack_o),
		.core_reset_o  (core_reset_o)
	);

	// the same select drives both the PLL and the blanking length
	pll_reconfig_seq i_pll_reconfig_seq (
		.clk_sys          (clk_sys),
		.rst_n_i          (rst_n_i),
		.pixbase_sel_i    (pixbase_sel_i),
		.reconfig_busy_i  (reconfig_busy_i),
		.rom_q_24_i       (rom_q_24_i),
		.rom_q_25_i       (rom_q_25_i),
		.rom_q_36_i       (rom_q_36_i),
		.write_from_rom_o (write_from_rom_o),
		.reconfig_o       (reconfig_o),
		.reconfig_reset_o (reconfig_reset_o),
		.rom_q_o          (rom_q_o)
	);

	back_porch_blank i_back_porch_blank (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.ce_pix_i      (ce_pix_i),
		.pixbase_sel_i (pixbase_sel_i),
		.vid_i         (vid_i),
		.vid_o         (vid_o)
	);

endmodule

/* tb/tb_mist_glue.sv */
`timescale 1ns/1ps
`include "mist_glue_defines.svh"

module tb_mist_glue;

	localparam int unsigned SEED = 32'h5cf46617;
	// all tests together run about 1500 cycles, mostly the reconfig timeout
	localparam int WATCHDOG_CYCLES = 4000;

	logic clk_sys = 1'b0;
	logic rst_n_i, downloading_i, ram_ack_i, ram_ready_i, reconfig_busy_i, ce_pix_i;
	logic rom_q_24_i, rom_q_25_i, rom_q_36_i;
	logic core_ack_o, core_reset_o, write_from_rom_o, reconfig_o, reconfig_reset_o, rom_q_o;
	logic [`MG_DIO_INDEX_W-1:0] dio_index_i;
	mist_glue_pkg::mem_req_t core_req_i, ram_req_o;
	mist_glue_pkg::loader_req_t loader_req_i;
	mist_glue_pkg::pixbase_e pixbase_sel_i;
	mist_glue_pkg::video_t vid_i, vid_o;

	mist_glue_top i_dut (.*);

	always #10 clk_sys = ~clk_sys;

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_bit(input string name, input logic exp, act);
		if (act !== exp)
			report_failure($sformatf("error: time %0t %s expected %b actual %b",
				$time, name, exp, act));
	endtask

	task automatic check_req(input string name, input mist_glue_pkg::mem_req_t exp, act);
		if (act !== exp)
			report_failure($sformatf("error: time %0t %s expected %h actual %h",
				$time, name, exp, act));
	endtask

	task automatic check_video(input string name, input mist_glue_pkg::video_t exp, act);
		if (act !== exp)
			report_failure($sformatf("error: time %0t %s expected %h actual %h",
				$time, name, exp, act));
	endtask

	// inputs change 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic test_reset_state();
		#1;
		check_bit("core_reset_o", 1'b1, core_reset_o);
		check_bit("pll pulse outputs", 1'b0, write_from_rom_o | reconfig_o | reconfig_reset_o);
		check_video("vid_o", '0, vid_o);
		// open a ROM download between two edges to see the loader strobe and rom_ready
		ram_ready_i = 1'b1;
		downloading_i = 1'b1;
		dio_index_i = `MG_DIO_INDEX_W'(`MG_IDX_ROM_LO);
		#1;
		check_bit("ram_req_o.stb", 1'b0, ram_req_o.stb);
		check_bit("core_reset_o", 1'b1, core_reset_o);
		ram_ready_i = 1'b0;
		downloading_i = 1'b0;
		dio_index_i = '0;
	endtask

	task automatic test_core_pass();
		logic [63:0] rnd;
		next_cycle();
		rnd = {$urandom, $urandom};
		core_req_i = rnd[$bits(mist_glue_pkg::mem_req_t)-1:0];
		core_req_i.stb = 1'b1;
		ram_ack_i = 1'b1;
		#1;
		// core path is combinational, same cycle
		check_req("ram_req_o", core_req_i, ram_req_o);
		check_bit("core_ack_o", 1'b1, core_ack_o);
		next_cycle();
		ram_ack_i = 1'b0;
		core_req_i = '0;
		#1;
		check_bit("core_ack_o", 1'b0, core_ack_o);
	endtask

	task automatic test_loader_write();
		logic [63:0] rnd;
		mist_glue_pkg::mem_req_t exp;
		// index 3 is no ROM image, the core keeps the bus
		next_cycle();
		downloading_i = 1'b1;
		dio_index_i = 8'd3;
		loader_req_i.we = 1'b1;
		next_cycle();
		check_bit("ram_req_o.stb", 1'b0, ram_req_o.stb);
		rnd = {$urandom, $urandom};
		loader_req_i = rnd[$bits(mist_glue_pkg::loader_req_t)-1:0];
		loader_req_i.we = 1'b1;
		dio_index_i = `MG_DIO_INDEX_W'(`MG_IDX_ROM_LO);
		exp = '{1'b1, 1'b1, loader_req_i.sel,
			loader_req_i.addr[`MG_MEM_ADDR_W-1:2], loader_req_i.data};
		next_cycle();
		loader_req_i.we = 1'b0;
		// ack held off for a while, request must not move
		repeat (1 + $urandom % 8) begin
			#1;
			check_req("ram_req_o", exp, ram_req_o);
			check_bit("core_ack_o", 1'b0, core_ack_o);
			next_cycle();
		end
		ram_ack_i = 1'b1;
		#1;
		check_bit("core_ack_o", 1'b0, core_ack_o);
		next_cycle();
		ram_ack_i = 1'b0;
		check_bit("ram_req_o.stb", 1'b0, ram_req_o.stb);
	endtask

	task automatic test_rom_ready();
		int n;
		next_cycle();
		ram_ready_i = 1'b1;
		repeat (3) begin
			next_cycle();
			check_bit("core_reset_o", 1'b1, core_reset_o);
		end
		// end of the ROM download releases the core
		downloading_i = 1'b0;
		for (n = 0; core_reset_o && n < 2; n++)
			next_cycle();
		check_bit("core_reset_o", 1'b0, core_reset_o);
		ram_ready_i = 1'b0;
		#1;
		check_bit("core_reset_o", 1'b1, core_reset_o);
	endtask

	task automatic test_pll_reconfig();
		int n;
		next_cycle();
		{rom_q_24_i, rom_q_25_i, rom_q_36_i} = 3'b010;
		reconfig_busy_i = 1'b1;
		pixbase_sel_i = mist_glue_pkg::PIXBASE_25;
		#1;
		check_bit("rom_q_o", 1'b1, rom_q_o);
		for (n = 0; !write_from_rom_o && n < 4; n++)
			next_cycle();
		check_bit("write_from_rom_o", 1'b1, write_from_rom_o);
		// controller still busy, no second load and no reconfig yet
		repeat (5) begin
			next_cycle();
			check_bit("write_from_rom_o", 1'b0, write_from_rom_o);
			check_bit("reconfig_o", 1'b0, reconfig_o);
		end
		reconfig_busy_i = 1'b0;
		for (n = 0; !reconfig_o && n < 4; n++)
			next_cycle();
		check_bit("reconfig_o", 1'b1, reconfig_o);
		// busy stuck high, expect the timeout reset
		reconfig_busy_i = 1'b1;
		for (n = 0; !reconfig_reset_o && n < 1100; n++)
			next_cycle();
		check_bit("reconfig_reset_o", 1'b1, reconfig_reset_o);
		if (n < 990 || n > 1010)
			report_failure($sformatf(
				"error: time %0t reconfig_reset_o delay expected 990 to 1010 actual %0d",
				$time, n));
		next_cycle();
		check_bit("reconfig_reset_o", 1'b0, reconfig_reset_o);
		reconfig_busy_i = 1'b0;
		{rom_q_24_i, rom_q_25_i, rom_q_36_i} = 3'b110;
		pixbase_sel_i = mist_glue_pkg::PIXBASE_36;
		#1;
		check_bit("rom_q_o", 1'b0, rom_q_o);
		rom_q_36_i = 1'b1;
		#1;
		check_bit("rom_q_o", 1'b1, rom_q_o);
	endtask

	// one hsync pulse, colour checked before and after the porch window
	task automatic run_porch(input mist_glue_pkg::pixbase_e mode, input int black_to, color_from);
		mist_glue_pkg::video_t blank;
		int k;
		next_cycle();
		pixbase_sel_i = mode;
		vid_i.hs = 1'b0;
		blank = vid_i;
		blank.rgb = '0;
		// registered hs and the counter clear lag two edges
		repeat (2)
			next_cycle();
		repeat (4) begin
			next_cycle();
			check_video("vid_o", blank, vid_o);
		end
		vid_i.hs = 1'b1;
		blank.hs = 1'b1;
		for (k = 1; k <= color_from + 4; k++) begin
			next_cycle();
			if (k <= black_to)
				check_video("vid_o", blank, vid_o);
			else if (k >= color_from)
				check_video("vid_o", vid_i, vid_o);
		end
	endtask

	task automatic test_back_porch();
		next_cycle();
		ce_pix_i = 1'b1;
		vid_i = {12'ha5c, 1'b0, 1'b1};
		run_porch(mist_glue_pkg::PIXBASE_25, 60, 70);
		run_porch(mist_glue_pkg::PIXBASE_24, 250, 262);
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n_i = 1'b0;
		{downloading_i, ram_ack_i, ram_ready_i, reconfig_busy_i, ce_pix_i} = 5'b0;
		{rom_q_24_i, rom_q_25_i, rom_q_36_i} = 3'b0;
		dio_index_i = '0;
		core_req_i = '0;
		loader_req_i = '0;
		pixbase_sel_i = mist_glue_pkg::PIXBASE_24;
		vid_i = '0;
		repeat (10)
			@(posedge clk_sys);
		#2;
		rst_n_i = 1'b1;
		test_reset_state();
		test_core_pass();
		test_loader_write();
		test_rom_ready();
		test_pll_reconfig();
		test_back_porch();
		$display("TESTS PASSED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES)
			@(posedge clk_sys);
		report_failure("timeout: the tests did not finish before the watchdog expired");
	end

endmodule

/* mist_glue.f */
+incdir+common
common/mist_glue_pkg.sv
design/mem_arbiter/mem_arbiter.sv
design/pll_reconfig/pll_reconfig_seq.sv
design/video_blank/back_porch_blank.sv
design/mist_glue_top.sv
tb/tb_mist_glue.sv

/* Bender.yml */
package:
  name: mist_glue

sources:
  - include_dirs:
      - common
    files:
      - common/mist_glue_pkg.sv
      - design/mem_arbiter/mem_arbiter.sv
      - design/pll_reconfig/pll_reconfig_seq.sv
      - design/video_blank/back_porch_blank.sv
      - design/mist_glue_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_mist_glue.sv
